/* hw/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

  // Hart count and index widths
  localparam int unsigned NHART      = 4;
  localparam int unsigned HARTSEL_W  = 2;
  localparam int unsigned DMI_ADDR_W = 7;

  // Debug spec 0.13
  localparam logic [3:0] DM_VERSION = 4'd2;

  // dmstatus bit positions, any bit of each all/any pair
  localparam int unsigned DMS_HAVERESET = 18;
  localparam int unsigned DMS_RESUMEACK = 16;
  localparam int unsigned DMS_NONEXIST  = 14;
  localparam int unsigned DMS_UNAVAIL   = 12;
  localparam int unsigned DMS_RUNNING   = 10;
  localparam int unsigned DMS_HALTED    = 8;
  localparam int unsigned DMS_AUTH      = 7;
  localparam int unsigned DMS_VERSION_W = 4;

  // DMI register map
  typedef enum logic [DMI_ADDR_W-1:0] {
    DMCONTROL = 7'h10,
    DMSTATUS  = 7'h11,
    HALTSUM0  = 7'h40
  } dmi_reg_e;

  typedef enum logic [1:0] {
    HART_RUNNING,
    HART_HALTING,
    HART_HALTED,
    HART_RESUMING
  } hart_state_e;

  // One-cycle pulses towards a single hart
  typedef struct packed {
    logic haltreq;
    logic resumereq;
    logic ackhavereset;
  } hart_req_t;

  typedef struct packed {
    logic halted;
    logic running;
    logic resumeack;
    logic havereset;
    logic nonexistent;
    logic unavail;
  } hart_status_t;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       rsvd_29;
    logic       ackhavereset;
    logic [1:0] rsvd_27_26;
    logic [9:0] hartsello;
    logic [13:0] rsvd_15_2;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

endpackage

`default_nettype wire

/* hw/dbg_dmi_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_dmi_apb (
  input  wire                                     i_clk,
  input  wire                                     i_rst,

  // APB slave
  input  wire                                     i_psel,
  input  wire                                     i_penable,
  input  wire                                     i_pwrite,
  input  wire  [dbg_pkg::DMI_ADDR_W-1:0]          i_paddr,
  input  wire  [31:0]                             i_pwdata,
  output logic [31:0]                             o_prdata,
  output logic                                    o_pready,
  output logic                                    o_pslverr,

  // Status words from the merger
  input  wire  [31:0]                             i_dmstatus,
  input  wire  [31:0]                             i_haltsum0,

  // Towards the harts
  output dbg_pkg::hart_req_t [dbg_pkg::NHART-1:0] o_req,
  output logic [dbg_pkg::HARTSEL_W:0]             o_hartsel,
  output logic                                    o_ndmreset,
  output logic                                    o_dmactive
);

  import dbg_pkg::*;

  dmi_reg_e                 addr;
  dmcontrol_t               wdata;
  dmcontrol_t               ctl_rd;
  logic                     access;
  logic                     addr_ok;
  logic                     ctl_wr;
  logic                     req_wr;
  logic [HARTSEL_W:0]       wr_sel;

  logic                     dmactive_q;
  logic                     ndmreset_q;
  logic [HARTSEL_W:0]       hartsel_q;
  hart_req_t [NHART-1:0]    req_q;

  assign addr   = dmi_reg_e'(i_paddr);
  assign wdata  = dmcontrol_t'(i_pwdata);
  assign access = i_psel & i_penable;

  always_comb begin
    case (addr)
      DMCONTROL, DMSTATUS, HALTSUM0: addr_ok = 1'b1;
      default:                       addr_ok = 1'b0;
    endcase
  end

  assign ctl_wr = access & i_pwrite & (addr == DMCONTROL);

  // Requests only while the DM is and stays active
  assign req_wr = ctl_wr & dmactive_q & wdata.dmactive;

  // Out-of-range selections collapse to NHART, meaning no hart
  assign wr_sel = (wdata.hartsello >= 10'(NHART)) ? (HARTSEL_W+1)'(NHART)
                                                  : wdata.hartsello[HARTSEL_W:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      hartsel_q  <= '0;
    end else if (ctl_wr) begin
      dmactive_q <= wdata.dmactive;
      if (dmactive_q && wdata.dmactive) begin
        ndmreset_q <= wdata.ndmreset;
        hartsel_q  <= wr_sel;
      end else begin
        // Inactive DM, everything but dmactive stays cleared
        ndmreset_q <= 1'b0;
        hartsel_q  <= '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      req_q <= '0;
    end else begin
      for (int h = 0; h < NHART; h++) begin
        req_q[h] <= '0;
        if (req_wr && wr_sel == (HARTSEL_W+1)'(h)) begin
          req_q[h].haltreq      <= wdata.haltreq;
          // haltreq wins over resumereq
          req_q[h].resumereq    <= wdata.resumereq & ~wdata.haltreq;
          req_q[h].ackhavereset <= wdata.ackhavereset;
        end
      end
    end
  end

  always_comb begin
    ctl_rd          = '0;
    ctl_rd.dmactive = dmactive_q;
    if (dmactive_q) begin
      ctl_rd.hartsello = 10'(hartsel_q);
      ctl_rd.ndmreset  = ndmreset_q;
    end
  end

  // Zero wait-state reads
  always_comb begin
    case (addr)
      DMCONTROL: o_prdata = ctl_rd;
      DMSTATUS:  o_prdata = i_dmstatus;
      HALTSUM0:  o_prdata = i_haltsum0;
      default:   o_prdata = '0;
    endcase
  end

  assign o_pready   = 1'b1;
  assign o_pslverr  = access & ~addr_ok;
  assign o_req      = req_q;
  assign o_hartsel  = hartsel_q;
  assign o_ndmreset = ndmreset_q;
  assign o_dmactive = dmactive_q;

endmodule

`default_nettype wire

/* hw/dbg_hart_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_hart_ctrl (
  input  wire                   i_clk,
  input  wire                   i_rst,
  input  wire                   i_dmactive,
  input  dbg_pkg::hart_req_t    i_req,

  // Hart side
  input  wire                   i_halted,
  input  wire                   i_nonexistent,
  input  wire                   i_unavail,
  input  wire                   i_under_reset,
  output logic                  o_debugint,
  output logic                  o_resumereq,

  output dbg_pkg::hart_status_t o_status
);

  import dbg_pkg::*;

  hart_state_e state_q;
  hart_state_e state_n;
  logic        resumeack_q;
  logic        resumeack_n;
  logic        havereset_q;
  logic        halted_q;
  logic        nonexistent_q;
  logic        unavail_q;

  always_comb begin
    state_n = state_q;
    if (!i_dmactive || i_under_reset) begin
      // Just track the hart
      state_n = i_halted ? HART_HALTED : HART_RUNNING;
    end else if (i_req.haltreq) begin
      state_n = i_halted ? HART_HALTED : HART_HALTING;
    end else if (i_req.resumereq) begin
      state_n = i_halted ? HART_RESUMING : HART_RUNNING;
    end else begin
      case (state_q)
        HART_RUNNING:  if (i_halted)  state_n = HART_HALTED;
        HART_HALTING:  if (i_halted)  state_n = HART_HALTED;
        HART_HALTED:   if (!i_halted) state_n = HART_RUNNING;
        HART_RESUMING: if (!i_halted) state_n = HART_RUNNING;
        default:                      state_n = HART_RUNNING;
      endcase
    end
  end

  always_comb begin
    resumeack_n = resumeack_q;
    if (!i_dmactive) begin
      resumeack_n = 1'b0;
    end else if (i_req.resumereq) begin
      // A running hart acks at once
      resumeack_n = ~i_halted;
    end else if (state_q == HART_RESUMING && !i_halted) begin
      resumeack_n = 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q       <= HART_RUNNING;
      resumeack_q   <= 1'b0;
      havereset_q   <= 1'b0;
      halted_q      <= 1'b0;
      nonexistent_q <= 1'b0;
      unavail_q     <= 1'b0;
    end else begin
      state_q       <= state_n;
      resumeack_q   <= resumeack_n;
      halted_q      <= i_halted;
      nonexistent_q <= i_nonexistent;
      unavail_q     <= i_unavail;
      if (i_under_reset) begin
        havereset_q <= 1'b1;
      end else if (i_req.ackhavereset) begin
        havereset_q <= 1'b0;
      end
    end
  end

  assign o_debugint  = i_dmactive & (state_q == HART_HALTING);
  assign o_resumereq = i_dmactive & (state_q == HART_RESUMING);

  always_comb begin
    o_status             = '0;
    o_status.halted      = halted_q;
    o_status.running     = ~(halted_q | nonexistent_q | unavail_q);
    o_status.resumeack   = resumeack_q;
    o_status.havereset   = havereset_q;
    o_status.nonexistent = nonexistent_q;
    o_status.unavail     = unavail_q;
  end

endmodule

`default_nettype wire

/* hw/dbg_status_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_status_merge (
  input  dbg_pkg::hart_status_t [dbg_pkg::NHART-1:0] i_status,
  input  wire  [dbg_pkg::HARTSEL_W:0]                i_hartsel,
  output logic [31:0]                                o_dmstatus,
  output logic [31:0]                                o_haltsum0
);

  import dbg_pkg::*;

  logic         sel_ok;
  hart_status_t sel;

  assign sel_ok = (i_hartsel < (HARTSEL_W+1)'(NHART));

  always_comb begin
    sel = '0;
    if (sel_ok) begin
      sel = i_status[i_hartsel[HARTSEL_W-1:0]];
    end
  end

  // Single hart selected, so all and any carry the same value
  always_comb begin
    o_dmstatus                              = '0;
    o_dmstatus[DMS_VERSION_W-1:0]           = DM_VERSION;
    o_dmstatus[DMS_AUTH]                    = 1'b1;
    if (sel_ok) begin
      o_dmstatus[DMS_HAVERESET +: 2] = {2{sel.havereset}};
      o_dmstatus[DMS_RESUMEACK +: 2] = {2{sel.resumeack}};
      o_dmstatus[DMS_NONEXIST  +: 2] = {2{sel.nonexistent}};
      o_dmstatus[DMS_UNAVAIL   +: 2] = {2{sel.unavail}};
      o_dmstatus[DMS_RUNNING   +: 2] = {2{sel.running}};
      o_dmstatus[DMS_HALTED    +: 2] = {2{sel.halted}};
    end else begin
      o_dmstatus[DMS_NONEXIST  +: 2] = 2'b11;
    end
  end

  always_comb begin
    o_haltsum0 = '0;
    for (int h = 0; h < NHART; h++) begin
      o_haltsum0[h] = i_status[h].halted;
    end
  end

endmodule

`default_nettype wire

/* hw/dbg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_top (
  input  wire                          i_clk,
  input  wire                          i_rst,

  // APB from the debug transport
  input  wire                          i_psel,
  input  wire                          i_penable,
  input  wire                          i_pwrite,
  input  wire  [dbg_pkg::DMI_ADDR_W-1:0] i_paddr,
  input  wire  [31:0]                  i_pwdata,
  output logic [31:0]                  o_prdata,
  output logic                         o_pready,
  output logic                         o_pslverr,

  // Hart side
  input  wire  [dbg_pkg::NHART-1:0]    i_hart_halted,
  input  wire  [dbg_pkg::NHART-1:0]    i_hart_nonexistent,
  input  wire  [dbg_pkg::NHART-1:0]    i_hart_unavail,
  input  wire  [dbg_pkg::NHART-1:0]    i_hart_under_reset,
  output logic [dbg_pkg::NHART-1:0]    o_debugint,
  output logic [dbg_pkg::NHART-1:0]    o_resumereq,
  output logic                         o_ndmreset,
  output logic                         o_dmactive
);

  import dbg_pkg::*;

  hart_req_t    [NHART-1:0] hart_req;
  hart_status_t [NHART-1:0] hart_status;
  logic [HARTSEL_W:0]       hartsel;
  logic [31:0]              dmstatus;
  logic [31:0]              haltsum0;

  dbg_dmi_apb u_dmi (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .i_dmstatus (dmstatus),
    .i_haltsum0 (haltsum0),
    .o_req      (hart_req),
    .o_hartsel  (hartsel),
    .o_ndmreset (o_ndmreset),
    .o_dmactive (o_dmactive)
  );

  for (genvar h = 0; h < NHART; h++) begin : g_hart
    dbg_hart_ctrl u_hart_ctrl (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_dmactive    (o_dmactive),
      .i_req         (hart_req[h]),
      .i_halted      (i_hart_halted[h]),
      .i_nonexistent (i_hart_nonexistent[h]),
      .i_unavail     (i_hart_unavail[h]),
      .i_under_reset (i_hart_under_reset[h]),
      .o_debugint    (o_debugint[h]),
      .o_resumereq   (o_resumereq[h]),
      .o_status      (hart_status[h])
    );
  end

  dbg_status_merge u_status (
    .i_status   (hart_status),
    .i_hartsel  (hartsel),
    .o_dmstatus (dmstatus),
    .o_haltsum0 (haltsum0)
  );

endmodule

`default_nettype wire

/* verification/dbg_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_assertions (
  input wire                                     i_clk,
  input wire                                     i_rst,
  input wire                                     i_psel,
  input wire                                     i_penable,
  input wire                                     i_pready,
  input wire [dbg_pkg::NHART-1:0]                i_debugint,
  input wire [dbg_pkg::NHART-1:0]                i_resumereq,
  input dbg_pkg::hart_req_t [dbg_pkg::NHART-1:0] i_hart_req,
  input wire                                     i_ndmreset,
  input wire                                     i_dmactive
);

  // No wait states on the DMI
  a_pready_in_access: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_psel && i_penable) |-> i_pready)
    else $error("pready low in an APB access cycle");

  a_halt_resume_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(|(i_debugint & i_resumereq)))
    else $error("debugint and resumereq both high for one hart");

  // Registered request pulses must not outlive dmactive
  a_inactive_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_dmactive |-> (i_debugint == '0 && i_resumereq == '0 && i_hart_req == '0))
    else $error("hart request high while dmactive is low");

  a_reset_outputs: assert property (@(posedge i_clk)
    i_rst |=> (i_debugint == '0 && i_resumereq == '0 && !i_ndmreset && !i_dmactive))
    else $error("outputs not low in the cycle after reset");

endmodule

bind dbg_top dbg_assertions u_assertions (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_psel      (i_psel),
  .i_penable   (i_penable),
  .i_pready    (o_pready),
  .i_debugint  (o_debugint),
  .i_resumereq (o_resumereq),
  .i_hart_req  (hart_req),
  .i_ndmreset  (o_ndmreset),
  .i_dmactive  (o_dmactive)
);

`default_nettype wire

/* verification/dbg_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_tb;

  import dbg_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_POLLS  = 16;
  localparam int MAX_WAIT   = 16;
  // Cycle budget of each test, in test order
  localparam int TEST_CYCLES = 20 + 30 + 200 + 60 + 80 + 40;
  localparam int WATCHDOG_NS = TEST_CYCLES * 4 * CLK_PERIOD;

  // dmstatus all/any pairs
  localparam logic [31:0] M_HAVERESET = 32'h000c_0000;
  localparam logic [31:0] M_RESUMEACK = 32'h0003_0000;
  localparam logic [31:0] M_NONEXIST  = 32'h0000_c000;
  localparam logic [31:0] M_UNAVAIL   = 32'h0000_3000;
  localparam logic [31:0] M_RUNNING   = 32'h0000_0c00;
  localparam logic [31:0] M_HALTED    = 32'h0000_0300;
  localparam logic [31:0] M_AUTH      = 32'h0000_0080;
  localparam logic [31:0] VERSION_013 = 32'h0000_0002;
  localparam logic [31:0] ALL_BITS    = 32'hffff_ffff;

  logic                  i_clk = 1'b0;
  logic                  i_rst;
  logic                  i_psel;
  logic                  i_penable;
  logic                  i_pwrite;
  logic [DMI_ADDR_W-1:0] i_paddr;
  logic [31:0]           i_pwdata;
  logic [31:0]           o_prdata;
  logic                  o_pready;
  logic                  o_pslverr;
  logic [NHART-1:0]      hart_halted = '0;
  logic [NHART-1:0]      hart_nonexist;
  logic [NHART-1:0]      hart_unavail;
  logic [NHART-1:0]      hart_under_reset;
  logic [NHART-1:0]      o_debugint;
  logic [NHART-1:0]      o_resumereq;
  logic                  o_ndmreset;
  logic                  o_dmactive;

  // Hart model state
  logic [NHART-1:0] hart_stall = '0;
  logic [NHART-1:0] dbg_seen = '0;
  logic [NHART-1:0] resume_seen = '0;
  int               hart_wait [NHART];
  logic [31:0]      lfsr_state = 32'ha027_e7ff;

  int err_count = 0;
  int chk_count = 0;

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  dbg_top DUT (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_psel             (i_psel),
    .i_penable          (i_penable),
    .i_pwrite           (i_pwrite),
    .i_paddr            (i_paddr),
    .i_pwdata           (i_pwdata),
    .o_prdata           (o_prdata),
    .o_pready           (o_pready),
    .o_pslverr          (o_pslverr),
    .i_hart_halted      (hart_halted),
    .i_hart_nonexistent (hart_nonexist),
    .i_hart_unavail     (hart_unavail),
    .i_hart_under_reset (hart_under_reset),
    .o_debugint         (o_debugint),
    .o_resumereq        (o_resumereq),
    .o_ndmreset         (o_ndmreset),
    .o_dmactive         (o_dmactive)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // Each hart toggles halted 1 to 8 cycles after a request it can act on
  always @(negedge i_clk) begin
    int d;
    if (i_rst) begin
      hart_halted = '0;
      for (int h = 0; h < NHART; h++) begin
        hart_wait[h] = 0;
      end
    end else begin
      dbg_seen    = dbg_seen | o_debugint;
      resume_seen = resume_seen | o_resumereq;
      for (int h = 0; h < NHART; h++) begin
        if (hart_wait[h] != 0) begin
          hart_wait[h] = hart_wait[h] - 1;
          if (hart_wait[h] == 0) begin
            hart_halted[h] = ~hart_halted[h];
          end
        end else if (!hart_stall[h] && ((o_debugint[h] && !hart_halted[h]) ||
                                        (o_resumereq[h] && hart_halted[h]))) begin
          d = 1;
          for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            if (lfsr_state[0]) begin
              d = d + (1 << b);
            end
          end
          hart_wait[h] = d;
        end
      end
    end
  end

  function automatic logic [31:0] dmctl_word(input logic halt, input logic resume,
                                             input logic ack, input logic [9:0] sel,
                                             input logic ndm, input logic act);
    dmcontrol_t w;
    w              = '0;
    w.haltreq      = halt;
    w.resumereq    = resume;
    w.ackhavereset = ack;
    w.hartsello    = sel;
    w.ndmreset     = ndm;
    w.dmactive     = act;
    return w;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_harts(input string name, input logic [NHART-1:0] got,
                             input logic [NHART-1:0] exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_slverr(input string name, input logic got, input logic exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [DMI_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge i_clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b1;
    i_paddr  = addr;
    i_pwdata = data;
    @(negedge i_clk);
    i_penable = 1'b1;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [DMI_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(negedge i_clk);
    i_psel   = 1'b1;
    i_pwrite = 1'b0;
    i_paddr  = addr;
    @(negedge i_clk);
    i_penable = 1'b1;
    // Mid access cycle, read data is combinational
    #(CLK_PERIOD / 4);
    data   = o_prdata;
    slverr = o_pslverr;
    @(negedge i_clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [DMI_ADDR_W-1:0] addr,
                            input logic [31:0] mask, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_read(addr, rd, err);
    check_slverr({name, " pslverr"}, err, 1'b0);
    check_word(name, rd & mask, exp);
  endtask

  task automatic wait_status(input string what, input logic [31:0] mask);
    logic [31:0] rd;
    logic        err;
    int          polls;
    rd    = '0;
    polls = 0;
    while ((rd & mask) == '0 && polls < MAX_POLLS) begin
      apb_read(DMSTATUS, rd, err);
      polls++;
    end
    if ((rd & mask) == '0) begin
      err_count++;
      $display("Timed out waiting for %s in dmstatus", what);
    end
  endtask

  task automatic wait_debugint(input int h);
    int cycles;
    cycles = 0;
    while (!o_debugint[h] && cycles < MAX_WAIT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (!o_debugint[h]) begin
      err_count++;
      $display("Timed out waiting for debugint of hart %0d", h);
    end
  endtask

  task automatic test_after_reset();
    logic [31:0] rd;
    logic        err;
    check_bit("o_dmactive", o_dmactive, 1'b0);
    check_bit("o_ndmreset", o_ndmreset, 1'b0);
    check_harts("o_debugint", o_debugint, '0);
    check_harts("o_resumereq", o_resumereq, '0);
    read_check("dmcontrol", DMCONTROL, ALL_BITS, 32'h0);
    apb_read(7'h05, rd, err);
    check_slverr("pslverr unknown addr", err, 1'b1);
    check_word("prdata unknown addr", rd, 32'h0);
  endtask

  task automatic test_activation();
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b0, 10'd0, 1'b0, 1'b1));
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b0, 10'd1, 1'b0, 1'b1));
    read_check("dmcontrol", DMCONTROL, ALL_BITS, 32'h0001_0001);
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b0, 10'd1, 1'b1, 1'b1));
    check_bit("o_ndmreset", o_ndmreset, 1'b1);
    read_check("dmcontrol", DMCONTROL, ALL_BITS, 32'h0001_0003);
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b0, 10'd1, 1'b0, 1'b1));
    check_bit("o_ndmreset", o_ndmreset, 1'b0);
  endtask

  task automatic test_halt();
    logic [NHART-1:0] halted_exp;
    halted_exp = '0;
    for (int h = 0; h < NHART; h++) begin
      apb_write(DMCONTROL, dmctl_word(1'b1, 1'b0, 1'b0, 10'(h), 1'b0, 1'b1));
      wait_status("anyhalted", M_HALTED);
      halted_exp[h] = 1'b1;
      read_check("dmstatus halted", DMSTATUS, M_HALTED, M_HALTED);
      read_check("haltsum0", HALTSUM0, ALL_BITS, 32'(halted_exp));
      check_harts("o_debugint seen", dbg_seen, halted_exp);
    end
    check_harts("o_debugint", o_debugint, '0);
  endtask

  task automatic test_resume();
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b1, 1'b0, 10'd2, 1'b0, 1'b1));
    wait_status("anyresumeack", M_RESUMEACK);
    read_check("dmstatus resume", DMSTATUS, M_HALTED | M_RESUMEACK | M_RUNNING,
               M_RESUMEACK | M_RUNNING);
    read_check("haltsum0", HALTSUM0, ALL_BITS, 32'h0000_000b);
    check_harts("o_resumereq seen", resume_seen, 4'b0100);
  endtask

  task automatic test_reset_avail();
    @(negedge i_clk);
    hart_under_reset[2] = 1'b1;
    repeat (2) @(negedge i_clk);
    hart_under_reset[2] = 1'b0;
    read_check("dmstatus havereset", DMSTATUS, M_HAVERESET, M_HAVERESET);
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b1, 10'd2, 1'b0, 1'b1));
    read_check("dmstatus havereset", DMSTATUS, M_HAVERESET, 32'h0);
    @(negedge i_clk);
    hart_nonexist[2] = 1'b1;
    read_check("dmstatus nonexistent", DMSTATUS, M_NONEXIST | M_RUNNING, M_NONEXIST);
    hart_nonexist[2] = 1'b0;
    @(negedge i_clk);
    hart_unavail[2] = 1'b1;
    read_check("dmstatus unavail", DMSTATUS, M_UNAVAIL | M_RUNNING, M_UNAVAIL);
    hart_unavail[2] = 1'b0;
    // Index past the last hart
    apb_write(DMCONTROL, dmctl_word(1'b0, 1'b0, 1'b0, 10'd4, 1'b0, 1'b1));
    read_check("dmstatus hartsel 4", DMSTATUS, ALL_BITS, M_NONEXIST | M_AUTH | VERSION_013);
    read_check("dmcontrol hartsel 4", DMCONTROL, ALL_BITS, 32'h0004_0001);
  endtask

  task automatic test_deactivation();
    hart_stall[2] = 1'b1;
    apb_write(DMCONTROL, dmctl_word(1'b1, 1'b0, 1'b0, 10'd2, 1'b0, 1'b1));
    wait_debugint(2);
    check_harts("o_debugint", o_debugint, 4'b0100);
    apb_write(DMCONTROL, 32'h0);
    check_harts("o_debugint", o_debugint, '0);
    check_bit("o_dmactive", o_dmactive, 1'b0);
    read_check("dmcontrol", DMCONTROL, ALL_BITS, 32'h0);
    apb_write(DMCONTROL, 32'h0003_0003);
    read_check("dmcontrol", DMCONTROL, ALL_BITS, 32'h0000_0001);
    hart_stall[2] = 1'b0;
  endtask

  initial begin
    i_rst            = 1'b1;
    i_psel           = 1'b0;
    i_penable        = 1'b0;
    i_pwrite         = 1'b0;
    i_paddr          = '0;
    i_pwdata         = '0;
    hart_nonexist    = '0;
    hart_unavail     = '0;
    hart_under_reset = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    test_after_reset();
    test_activation();
    test_halt();
    test_resume();
    test_reset_avail();
    test_deactivation();
    $display("Checks: %0d, errors: %0d", chk_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hw/dbg_pkg.sv
hw/dbg_dmi_apb.sv
hw/dbg_hart_ctrl.sv
hw/dbg_status_merge.sv
hw/dbg_top.sv
verification/dbg_assertions.sv
verification/dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug module testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module dbg_tb -Mdir "$BUILD_DIR" -o dbg_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/dbg_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
